// ==== bench/spi_cmd_checker.sv ====
`timescale 1ns/1ns

module spi_cmd_checker (
    input logic sck,
    input logic rst,
    input logic cs_n,
    input logic spi_oe,
    input logic vert_hdr_valid,
    input logic vert_valid,
    input logic tri_hdr_valid,
    input logic tri_valid
);

    // reply only inside a frame
    oe_in_frame: assert property (@(posedge sck) disable iff (rst) !(spi_oe && cs_n))
        else $error("spi_oe high while cs_n is high");

    one_kind: assert property (@(posedge sck) disable iff (rst) !(vert_valid && tri_valid))
        else $error("vert_valid and tri_valid high together");

    quiet_in_reset: assert property (@(posedge sck)
        rst |-> !(spi_oe || vert_valid || tri_valid || vert_hdr_valid || tri_hdr_valid))
        else $error("output active during reset");

endmodule

bind spi_cmd_top spi_cmd_checker u_checker (
    .sck, .rst, .cs_n, .spi_oe,
    .vert_hdr_valid, .vert_valid, .tri_hdr_valid, .tri_valid
);

// ==== bench/spi_cmd_tb.sv ====
`timescale 1ns/1ns
`include "spi_cmd_settings.svh"

module spi_cmd_tb
    import geom_pkg::*;
    import proto_pkg::*;
();

    localparam int VERT_NIBS = `VERT_W / `SPI_NIB_W;
    localparam int TRI_NIBS  = `TRI_W / `SPI_NIB_W;
    localparam int BIG_COUNT = 3000;
    localparam int MAX_BIG   = 4;       // big triangle frames before giving up
    localparam int FRAMES    = 4 + MAX_BIG + 1;
    localparam int TEST_NIBS = 3 * (4 + 20 * VERT_NIBS) + (4 + 20 * TRI_NIBS) + 1
                             + MAX_BIG * (4 + BIG_COUNT * TRI_NIBS);
    localparam int WATCHDOG_NS = 80 * TEST_NIBS + FRAMES * 40 * 40 + 2000;
    localparam int REPLY_WAIT  = 32;    // cycles from last nibble to end of reply

    logic                  sck, rst, cs_n;
    logic [`SPI_NIB_W-1:0] spi_din, spi_dout;
    logic                  spi_oe, vert_hdr_valid, vert_valid, tri_hdr_valid, tri_valid;
    buf_id_t               vert_id, tri_id;
    mem_addr_t             vert_base, tri_base;
    elem_count_t           vert_count, tri_count;
    vertex_t               vert_data;
    tri_t                  tri_data;

    logic [31:0]  lfsr;
    logic [7:0]   model_vert_id, model_tri_id;
    int           model_vert_base, model_tri_base;
    logic [33:0]  exp_hdr[$];       // kind, id, base, count
    logic [108:0] exp_elem[$];      // kind, data
    logic [3:0]   exp_nib[$];
    logic [107:0] frame_elems[$];
    logic [3:0]   last_reply_nib;
    int           checks, errors, tests_run, tests_failed, test_err_base;

    spi_cmd_top UUT (.*);

    initial begin
        sck = 1'b0;
        forever #20 sck = ~sck;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("TB FAILED");
        $finish;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [107:0] rand_bits(input int n);
        logic [107:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[106:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [11:0] rand_count();
        return 12'(rand_bits(5) % 20 + 1);     // 1 to 20
    endfunction

    // expected header, elements and reply nibbles of one frame
    function automatic logic [3:0] predict_frame(input logic [3:0] op, input logic [11:0] cnt);
        logic       kind;
        logic [7:0] id;
        int         base;
        logic       oom;
        logic [3:0] st;
        if (op != OP_CREATE_VERT && op != OP_CREATE_TRI) begin
            exp_nib.push_back(ST_INVALID_OPCODE);
            return ST_INVALID_OPCODE;
        end
        kind = (op == OP_CREATE_TRI);
        id   = kind ? model_tri_id : model_vert_id;
        base = kind ? model_tri_base : model_vert_base;
        oom  = (base + int'(cnt)) > (kind ? `TRI_MEM_DEPTH : `VERT_MEM_DEPTH);
        st   = oom ? ST_OUT_OF_MEMORY : ST_OK;
        exp_hdr.push_back({kind, id, 13'(base), cnt});
        if (!oom) begin
            foreach (frame_elems[i])
                exp_elem.push_back({kind, frame_elems[i]});
        end
        exp_nib.push_back(id[7:4]);
        exp_nib.push_back(id[3:0]);
        exp_nib.push_back(st);
        if (kind) begin
            model_tri_id = id + 8'd1;     // spent even when out of memory
            if (!oom)
                model_tri_base = base + int'(cnt);
        end else begin
            model_vert_id = id + 8'd1;
            if (!oom)
                model_vert_base = base + int'(cnt);
        end
        return st;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_header(input logic kind, input logic [7:0] id,
                                  input logic [12:0] base, input logic [11:0] cnt);
        logic [33:0] e;
        assert (exp_hdr.size() != 0) else begin
            $display("unexpected %s header pulse at %0t ns", kind ? "tri" : "vert", $time);
            errors++;
        end
        if (exp_hdr.size() != 0) begin
            e = exp_hdr.pop_front();
            check_value("tri_hdr_valid", 128'(kind), 128'(e[33]));
            check_value(kind ? "tri_id" : "vert_id", 128'(id), 128'(e[32:25]));
            check_value(kind ? "tri_base" : "vert_base", 128'(base), 128'(e[24:12]));
            check_value(kind ? "tri_count" : "vert_count", 128'(cnt), 128'(e[11:0]));
        end
    endtask

    task automatic compare_element(input logic kind, input logic [107:0] data);
        logic [108:0] e;
        assert (exp_elem.size() != 0) else begin
            $display("unexpected %s element pulse at %0t ns", kind ? "tri" : "vert", $time);
            errors++;
        end
        if (exp_elem.size() != 0) begin
            e = exp_elem.pop_front();
            check_value("tri_valid", 128'(kind), 128'(e[108]));
            check_value(kind ? "tri_data" : "vert_data", 128'(data), 128'(e[107:0]));
        end
    endtask

    task automatic compare_nibble(input logic [3:0] nib);
        assert (exp_nib.size() != 0) else begin
            $display("unexpected reply nibble %h at %0t ns", nib, $time);
            errors++;
        end
        if (exp_nib.size() != 0)
            check_value("spi_dout", 128'(nib), 128'(exp_nib.pop_front()));
    endtask

    // geometry pulses change on the rising edge, reply nibbles on the falling edge
    always @(negedge sck) begin
        if (!rst) begin
            if (vert_hdr_valid) compare_header(1'b0, vert_id, vert_base, vert_count);
            if (tri_hdr_valid)  compare_header(1'b1, tri_id, tri_base, tri_count);
            if (vert_valid)     compare_element(1'b0, vert_data);
            if (tri_valid)      compare_element(1'b1, 108'(tri_data));
        end
    end

    always @(posedge sck) begin
        if (!rst && spi_oe) begin
            compare_nibble(spi_dout);
            last_reply_nib = spi_dout;
        end
    end

    task automatic send_nibble(input logic [3:0] nib);
        spi_din = nib;
        @(negedge sck);
    endtask

    task automatic wait_reply();
        int cycles;
        bit seen_oe;
        cycles  = 0;
        seen_oe = 1'b0;
        while (!(seen_oe && !spi_oe) && cycles <= REPLY_WAIT) begin
            @(posedge sck);
            if (spi_oe)
                seen_oe = 1'b1;
            cycles++;
        end
        assert (seen_oe && !spi_oe) else begin
            $display("reply did not finish within %0d cycles at %0t ns", REPLY_WAIT, $time);
            errors++;
        end
    endtask

    task automatic run_frame(input logic [3:0] op, input logic [11:0] cnt,
                             output logic [3:0] st);
        bit valid_op;
        int nibs;
        valid_op = (op == OP_CREATE_VERT || op == OP_CREATE_TRI);
        nibs     = (op == OP_CREATE_TRI) ? TRI_NIBS : VERT_NIBS;
        frame_elems.delete();
        if (valid_op) begin
            for (int i = 0; i < int'(cnt); i++)
                frame_elems.push_back(rand_bits(nibs * `SPI_NIB_W));
        end
        void'(predict_frame(op, cnt));
        last_reply_nib = '0;
        @(negedge sck);
        cs_n    = 1'b0;
        spi_din = op;       // held until the first ready edge takes it
        repeat (`SETTLE_CYCLES + 1) @(negedge sck);
        if (valid_op) begin
            for (int k = 2; k >= 0; k--)
                send_nibble(cnt[k*4 +: 4]);
            foreach (frame_elems[i]) begin
                for (int k = nibs - 1; k >= 0; k--)
                    send_nibble(frame_elems[i][k*4 +: 4]);
            end
        end
        spi_din = '0;
        wait_reply();
        st = last_reply_nib;    // status nibble as sent by the DUT
        assert (exp_hdr.size() == 0 && exp_elem.size() == 0 && exp_nib.size() == 0) else begin
            $display("frame ended at %0t ns with %0d headers, %0d elements, %0d nibbles missing",
                     $time, exp_hdr.size(), exp_elem.size(), exp_nib.size());
            errors++;
        end
        exp_hdr.delete();
        exp_elem.delete();
        exp_nib.delete();
        @(negedge sck);
        cs_n = 1'b1;
        repeat (3) @(negedge sck);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    initial begin
        logic [3:0] st;
        int         big;
        bit         oom_seen;
        lfsr            = 32'h5d3a_2014;
        model_vert_id   = '0;
        model_tri_id    = '0;
        model_vert_base = 0;
        model_tri_base  = 0;
        last_reply_nib  = '0;
        checks          = 0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        test_err_base   = 0;
        rst             = 1'b1;
        cs_n            = 1'b1;
        spi_din         = '0;
        repeat (5) @(posedge sck);
        @(negedge sck);
        rst = 1'b0;

        run_frame(OP_CREATE_VERT, rand_count(), st);
        finish_test("first vertex buffer");
        run_frame(OP_CREATE_VERT, rand_count(), st);
        finish_test("second vertex buffer");
        run_frame(OP_CREATE_TRI, rand_count(), st);
        finish_test("triangle buffer");
        run_frame(4'h9, 12'd0, st);
        finish_test("unknown opcode");

        big      = 0;
        oom_seen = 1'b0;
        while (!oom_seen && big < MAX_BIG) begin
            run_frame(OP_CREATE_TRI, 12'(BIG_COUNT), st);
            oom_seen = (st == ST_OUT_OF_MEMORY);
            big++;
        end
        assert (oom_seen) else begin
            $display("no triangle buffer ran out of memory after %0d frames", big);
            errors++;
        end
        run_frame(OP_CREATE_VERT, rand_count(), st);
        finish_test("triangle memory exhaustion");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/geom_pkg.sv
rtl/proto_pkg.sv
rtl/link_settle.sv
rtl/nibble_shifter.sv
rtl/buffer_allocator.sv
rtl/cmd_sequencer.sv
rtl/reply_serializer.sv
rtl/spi_cmd_top.sv
bench/spi_cmd_checker.sv
bench/spi_cmd_tb.sv

// ==== rtl/buffer_allocator.sv ====
`timescale 1ns/1ns

module buffer_allocator
    import geom_pkg::*;
#(
    parameter int MEM_DEPTH = 8192
) (
    input  logic        sck,
    input  logic        rst,
    input  logic        alloc,
    input  elem_count_t count,
    output buf_id_t     id,
    output mem_addr_t   base,
    output logic        oom
);

    // one spare bit so a completely filled memory is still visible
    localparam int BW = $bits(mem_addr_t) + 1;

    logic [BW-1:0] next_base;
    logic [BW-1:0] end_addr;

    assign end_addr = next_base + BW'(count);
    assign oom      = end_addr > BW'(MEM_DEPTH);
    assign base     = next_base[BW-2:0];

    // id and base show the pending allocation until alloc takes it
    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            id        <= '0;
            next_base <= '0;
        end else if (alloc) begin
            id <= id + 1'b1;    // id is spent even on failure
            if (!oom)
                next_base <= end_addr;
        end
    end

endmodule

// ==== rtl/cmd_sequencer.sv ====
`timescale 1ns/1ns
`include "spi_cmd_settings.svh"

module cmd_sequencer
    import geom_pkg::*;
    import proto_pkg::*;
(
    input  logic                  sck,
    input  logic                  rst,
    input  logic                  ready,
    input  logic                  cs_n,
    input  logic [`SPI_NIB_W-1:0] spi_din,
    // nibble shifters
    output logic                  shift_clear,
    output logic                  cnt_shift_en,
    output logic                  vert_shift_en,
    output logic                  tri_shift_en,
    input  logic                  cnt_full,
    input  logic                  vert_full,
    input  logic                  tri_full,
    input  elem_count_t           count,
    // allocators
    output logic                  vert_alloc,
    output logic                  tri_alloc,
    input  buf_id_t               vert_id,
    input  buf_id_t               tri_id,
    input  logic                  vert_oom,
    input  logic                  tri_oom,
    // geometry strobes
    output logic                  vert_hdr_valid,
    output logic                  vert_valid,
    output logic                  tri_hdr_valid,
    output logic                  tri_valid,
    output logic                  payload_done,
    // reply
    output logic                  reply_start,
    output buf_id_t               reply_id,
    output status_e               reply_status,
    output logic                  id_en,
    input  logic                  reply_done
);

    seq_state_e  state;
    logic        is_tri;
    logic        oom_r;
    logic        elem_full;
    elem_count_t elem_cnt;

    assign shift_clear   = (state == S_OPCODE);
    assign cnt_shift_en  = ready && (state == S_COUNT);
    assign vert_shift_en = ready && (state == S_ELEM) && !is_tri;
    assign tri_shift_en  = ready && (state == S_ELEM) && is_tri;
    assign elem_full     = is_tri ? tri_full : vert_full;

    // allocation is taken while the header is on the bus
    assign vert_alloc = vert_hdr_valid;
    assign tri_alloc  = tri_hdr_valid;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            state          <= S_OPCODE;
            is_tri         <= 1'b0;
            oom_r          <= 1'b0;
            elem_cnt       <= '0;
            vert_hdr_valid <= 1'b0;
            tri_hdr_valid  <= 1'b0;
            vert_valid     <= 1'b0;
            tri_valid      <= 1'b0;
            payload_done   <= 1'b0;
            reply_start    <= 1'b0;
            reply_id       <= '0;
            reply_status   <= ST_OK;
            id_en          <= 1'b0;
        end else begin
            vert_hdr_valid <= 1'b0;
            tri_hdr_valid  <= 1'b0;
            vert_valid     <= 1'b0;
            tri_valid      <= 1'b0;
            payload_done   <= 1'b0;
            reply_start    <= 1'b0;
            if (cs_n) begin
                state    <= S_OPCODE;   // frame ended, drop whatever was going on
                elem_cnt <= '0;
            end else begin
                case (state)
                    S_OPCODE: begin
                        if (ready) begin
                            case (opcode_e'(spi_din))
                                OP_CREATE_VERT: begin
                                    is_tri <= 1'b0;
                                    state  <= S_COUNT;
                                end
                                OP_CREATE_TRI: begin
                                    is_tri <= 1'b1;
                                    state  <= S_COUNT;
                                end
                                default: begin
                                    reply_status <= ST_INVALID_OPCODE;
                                    id_en        <= 1'b0;
                                    payload_done <= 1'b1;
                                    reply_start  <= 1'b1;
                                    state        <= S_REPLY;
                                end
                            endcase
                        end
                    end
                    S_COUNT: begin
                        if (cnt_full) begin
                            vert_hdr_valid <= !is_tri;
                            tri_hdr_valid  <= is_tri;
                            elem_cnt       <= '0;
                            state          <= S_ELEM;
                        end
                    end
                    S_ELEM: begin
                        if (vert_hdr_valid || tri_hdr_valid) begin
                            reply_id <= is_tri ? tri_id : vert_id;
                            oom_r    <= is_tri ? tri_oom : vert_oom;
                        end
                        if (elem_full) begin
                            // elements still consumed on oom, just not emitted
                            vert_valid <= !is_tri && !oom_r;
                            tri_valid  <= is_tri && !oom_r;
                            if (elem_cnt == count - 1'b1) begin
                                reply_status <= oom_r ? ST_OUT_OF_MEMORY : ST_OK;
                                id_en        <= 1'b1;
                                payload_done <= 1'b1;
                                reply_start  <= 1'b1;
                                elem_cnt     <= '0;
                                state        <= S_REPLY;
                            end else begin
                                elem_cnt <= elem_cnt + 1'b1;
                            end
                        end
                    end
                    S_REPLY: begin
                        if (reply_done)
                            state <= S_OPCODE;
                    end
                    default: state <= S_OPCODE;
                endcase
            end
        end
    end

endmodule

// ==== rtl/geom_pkg.sv ====
`include "spi_cmd_settings.svh"

package geom_pkg;

    // x, y, z then three attribute nibbles, msb first
    typedef logic [`VERT_W-1:0] vertex_t;

    // corner indices v0, v1, v2, each VIDX_W wide
    typedef logic [`TRI_W-1:0] tri_t;

    typedef logic [`VIDX_W-1:0] elem_count_t;

    typedef logic [`BUF_ID_W-1:0] buf_id_t;

    typedef logic [$clog2(`VERT_MEM_DEPTH)-1:0] mem_addr_t;

endpackage

// ==== rtl/link_settle.sv ====
`timescale 1ns/1ns
`include "spi_cmd_settings.svh"

module link_settle (
    input  logic sck,
    input  logic rst,
    input  logic cs_n,
    input  logic payload_done,
    output logic ready,
    output logic turn_done
);

    localparam int SCW = $clog2(`SETTLE_CYCLES + 1);
    localparam int TCW = $clog2(`TURN_CYCLES + 1);

    logic [SCW-1:0] settle_cnt;
    logic [TCW-1:0] turn_cnt;
    logic           pausing;
    logic           locked;     // payload seen, hold off until cs_n rises

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            settle_cnt <= '0;
            turn_cnt   <= '0;
            pausing    <= 1'b0;
            locked     <= 1'b0;
            ready      <= 1'b0;
            turn_done  <= 1'b0;
        end else begin
            turn_done <= 1'b0;
            if (cs_n) begin
                settle_cnt <= '0;
                pausing    <= 1'b0;
                locked     <= 1'b0;
                ready      <= 1'b0;
            end else if (payload_done) begin
                ready    <= 1'b0;
                locked   <= 1'b1;
                pausing  <= 1'b1;
                turn_cnt <= TCW'(`TURN_CYCLES - 1);
            end else if (pausing) begin
                if (turn_cnt == '0) begin
                    pausing   <= 1'b0;
                    turn_done <= 1'b1;
                end else begin
                    turn_cnt <= turn_cnt - 1'b1;
                end
            end else if (!ready && !locked) begin
                if (settle_cnt == SCW'(`SETTLE_CYCLES - 1))
                    ready <= 1'b1;
                else
                    settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/nibble_shifter.sv ====
`timescale 1ns/1ns
`include "spi_cmd_settings.svh"

module nibble_shifter #(
    parameter type payload_t = logic [`SPI_NIB_W-1:0]
) (
    input  logic                  sck,
    input  logic                  rst,
    input  logic                  shift_en,
    input  logic                  clear,
    input  logic [`SPI_NIB_W-1:0] nib,
    output payload_t              payload,
    output logic                  full
);

    localparam int W    = $bits(payload_t);
    localparam int NIBS = W / `SPI_NIB_W;
    localparam int CW   = $clog2(NIBS + 1);

    logic [W-1:0]  sreg;
    logic [CW-1:0] nib_cnt;

    assign payload = payload_t'(sreg);
    assign full    = shift_en && (nib_cnt == CW'(NIBS - 1));   // completing shift

    // msb nibble arrives first
    always_ff @(posedge sck) begin
        if (shift_en)
            sreg <= (sreg << `SPI_NIB_W) | W'(nib);
    end

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            nib_cnt <= '0;
        end else if (clear) begin
            nib_cnt <= '0;
        end else if (shift_en) begin
            if (full)
                nib_cnt <= '0;
            else
                nib_cnt <= nib_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/proto_pkg.sv ====
package proto_pkg;

    typedef enum logic [3:0] {
        OP_CREATE_VERT = 4'd1,
        OP_CREATE_TRI  = 4'd2
    } opcode_e;

    typedef enum logic [3:0] {
        ST_OK             = 4'd0,
        ST_OUT_OF_MEMORY  = 4'd1,
        ST_INVALID_OPCODE = 4'd2
    } status_e;

    typedef enum logic [2:0] {
        S_OPCODE,
        S_COUNT,
        S_ELEM,
        S_REPLY     // waiting for the reply to go out
    } seq_state_e;

endpackage

// ==== rtl/reply_serializer.sv ====
`timescale 1ns/1ns
`include "spi_cmd_settings.svh"

module reply_serializer
    import geom_pkg::*;
    import proto_pkg::*;
(
    input  logic                  sck,
    input  logic                  rst,
    input  logic                  turn_done,
    input  logic                  reply_start,
    input  logic                  id_en,
    input  buf_id_t               reply_id,
    input  status_e               reply_status,
    output logic [`SPI_NIB_W-1:0] spi_dout,
    output logic                  spi_oe,
    output logic                  reply_done
);

    buf_id_t    id_r;
    status_e    status_r;
    logic       id_en_r;
    logic [1:0] step;       // 1: id low next, 2: status next, 3: release
    logic       last_n;     // one full cycle wide, seen by exactly one rising edge

    always_ff @(negedge sck) begin
        if (reply_start) begin
            id_r     <= reply_id;
            status_r <= reply_status;
            id_en_r  <= id_en;
        end
    end

    always_ff @(negedge sck or posedge rst) begin
        if (rst) begin
            spi_dout <= '0;
            spi_oe   <= 1'b0;
            step     <= 2'd0;
            last_n   <= 1'b0;
        end else begin
            last_n <= 1'b0;
            if (!spi_oe) begin
                if (turn_done) begin
                    spi_oe <= 1'b1;
                    if (id_en_r) begin
                        spi_dout <= id_r[`BUF_ID_W-1 -: `SPI_NIB_W];
                        step     <= 2'd1;
                    end else begin
                        spi_dout <= status_r;   // status-only reply
                        step     <= 2'd3;
                    end
                end
            end else begin
                case (step)
                    2'd1: begin
                        spi_dout <= id_r[`SPI_NIB_W-1:0];
                        step     <= 2'd2;
                    end
                    2'd2: begin
                        spi_dout <= status_r;
                        step     <= 2'd3;
                    end
                    default: begin
                        spi_oe <= 1'b0;
                        step   <= 2'd0;
                        last_n <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge sck or posedge rst) begin
        if (rst)
            reply_done <= 1'b0;
        else
            reply_done <= last_n;
    end

endmodule

// ==== rtl/spi_cmd_settings.svh ====
`ifndef SPI_CMD_SETTINGS_SVH
`define SPI_CMD_SETTINGS_SVH

// link
`define SPI_NIB_W       4

// geometry payloads
`define VERT_W          108     // 3 x 32-bit coords + 3 x 4-bit attrs
`define VIDX_W          12      // element count, also corner index
`define TRI_W           36      // three corner indices
`define BUF_ID_W        8

// memory sizes in elements
`define VERT_MEM_DEPTH  8192
`define TRI_MEM_DEPTH   8192

`define SETTLE_CYCLES   8       // after cs_n falls
`define TURN_CYCLES     3       // before the reply

`endif

// ==== rtl/spi_cmd_top.sv ====
`timescale 1ns/1ns
`include "spi_cmd_settings.svh"

module spi_cmd_top
    import geom_pkg::*;
    import proto_pkg::*;
(
    input  logic                  sck,
    input  logic                  rst,
    input  logic                  cs_n,
    input  logic [`SPI_NIB_W-1:0] spi_din,
    output logic [`SPI_NIB_W-1:0] spi_dout,
    output logic                  spi_oe,
    output logic                  vert_hdr_valid,
    output logic                  vert_valid,
    output buf_id_t               vert_id,
    output mem_addr_t             vert_base,
    output elem_count_t           vert_count,
    output vertex_t               vert_data,
    output logic                  tri_hdr_valid,
    output logic                  tri_valid,
    output buf_id_t               tri_id,
    output mem_addr_t             tri_base,
    output elem_count_t           tri_count,
    output tri_t                  tri_data
);

    logic        ready, payload_done, turn_done;
    logic        shift_clear, cnt_shift_en, vert_shift_en, tri_shift_en;
    logic        cnt_full, vert_full, tri_full;
    logic        vert_alloc, tri_alloc, vert_oom, tri_oom;
    logic        reply_start, id_en, reply_done;
    elem_count_t count;
    buf_id_t     reply_id;
    status_e     reply_status;

    // one count register serves both buffer kinds
    assign vert_count = count;
    assign tri_count  = count;

    link_settle u_settle (.sck, .rst, .cs_n, .payload_done, .ready, .turn_done);

    nibble_shifter #(.payload_t(elem_count_t)) u_cnt_shift (.sck, .rst,
        .shift_en(cnt_shift_en), .clear(shift_clear), .nib(spi_din),
        .payload(count), .full(cnt_full));
    nibble_shifter #(.payload_t(vertex_t)) u_vert_shift (.sck, .rst,
        .shift_en(vert_shift_en), .clear(shift_clear), .nib(spi_din),
        .payload(vert_data), .full(vert_full));
    nibble_shifter #(.payload_t(tri_t)) u_tri_shift (.sck, .rst,
        .shift_en(tri_shift_en), .clear(shift_clear), .nib(spi_din),
        .payload(tri_data), .full(tri_full));

    buffer_allocator #(.MEM_DEPTH(`VERT_MEM_DEPTH)) u_vert_alloc (.sck, .rst,
        .alloc(vert_alloc), .count, .id(vert_id), .base(vert_base), .oom(vert_oom));
    buffer_allocator #(.MEM_DEPTH(`TRI_MEM_DEPTH)) u_tri_alloc (.sck, .rst,
        .alloc(tri_alloc), .count, .id(tri_id), .base(tri_base), .oom(tri_oom));

    cmd_sequencer u_seq (.sck, .rst, .ready, .cs_n, .spi_din,
        .shift_clear, .cnt_shift_en, .vert_shift_en, .tri_shift_en,
        .cnt_full, .vert_full, .tri_full, .count,
        .vert_alloc, .tri_alloc, .vert_id, .tri_id, .vert_oom, .tri_oom,
        .vert_hdr_valid, .vert_valid, .tri_hdr_valid, .tri_valid, .payload_done,
        .reply_start, .reply_id, .reply_status, .id_en, .reply_done);

    reply_serializer u_reply (.sck, .rst, .turn_done, .reply_start, .id_en,
        .reply_id, .reply_status, .spi_dout, .spi_oe, .reply_done);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spi_cmd testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module spi_cmd_tb -Mdir "$OBJ" -o spi_cmd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/spi_cmd_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0
